/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

  localparam int LINES = 64;
  localparam int ROWS_PER_LINE = 4;
  localparam int MEM_LATENCY = 3;    // Read acceptance to first beat
  localparam int MEM_BEAT_BITS = 12; // log2 of modelled beats

  typedef logic [29:0] word_addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0] byte_mask_t;   // All zero for a read
  typedef logic [19:0] tag_t;
  typedef logic [5:0] index_t;
  typedef logic [1:0] row_t;
  typedef logic [1:0] bank_t;
  typedef logic [27:0] mem_addr_t;   // Tag, index, row
  typedef logic [127:0] mem_data_t;
  typedef logic [15:0] mem_mask_t;

  // Tag SRAM entry: tag in 31:12, valid in 11, dirty in 10
  typedef logic [31:0] meta_t;

  // Field positions inside a word address
  typedef struct packed {
    tag_t   tag;   // 29:10
    index_t index; // 9:4
    row_t   row;   // 3:2
    bank_t  bank;  // 1:0
  } addr_fields_t;

  typedef struct packed {
    word_addr_t addr;
    word_t      data;
    byte_mask_t wmask;
  } cpu_req_t;

  typedef struct packed {
    mem_addr_t addr;
    logic      rw;    // Set for write
  } mem_req_t;

  typedef struct packed {
    mem_data_t data;
    mem_mask_t mask;
  } mem_wdata_t;

  typedef enum logic [2:0] {
    idle,
    meta,
    wb_wait,
    wb_send,
    fill_req,
    fill_wait
  } cache_state_e;

endpackage

`default_nettype wire

/* sram_1rw.sv */
`default_nettype none

// Single-port RAM, one word wide, byte-masked write
module sram_1rw #(
  parameter int DEPTH_BITS = 8
) (
  input  wire logic                  clk,
  input  wire logic                  we,
  input  wire cache_pkg::byte_mask_t wmask,
  input  wire logic [DEPTH_BITS-1:0] addr,
  input  wire cache_pkg::word_t      din,
  output cache_pkg::word_t           dout
);
  import cache_pkg::*;

  word_t mem [2**DEPTH_BITS];

  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < $bits(byte_mask_t); i++) begin
        if (wmask[i]) begin
          mem[addr][i*8 +: 8] <= din[i*8 +: 8];
        end
      end
    end
    dout <= mem[addr]; // Old data on a write
  end

endmodule

`default_nettype wire

/* cache.sv */
`default_nettype none

module cache (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 cpu_req_valid,
  input  wire cache_pkg::cpu_req_t  cpu_req,
  output logic                      cpu_req_ready,
  output logic                      cpu_resp_valid,
  output cache_pkg::word_t          cpu_resp_data,
  output logic                      mem_req_valid,
  input  wire logic                 mem_req_ready,
  output cache_pkg::mem_req_t       mem_req,
  output logic                      mem_wdata_valid,
  input  wire logic                 mem_wdata_ready,
  output cache_pkg::mem_wdata_t     mem_wdata,
  input  wire logic                 mem_resp_valid,
  input  wire cache_pkg::mem_data_t mem_resp_data
);
  import cache_pkg::*;

  cache_state_e state;
  cpu_req_t     req_q;         // Request being served
  addr_fields_t in_f;
  addr_fields_t req_f;
  logic         line_ok;       // Line of req_q known resident
  row_t         row_cnt;       // Write-back and fill row

  meta_t        meta_dout;
  meta_t        meta_din;
  logic         meta_we;
  index_t       meta_addr;
  tag_t         stored_tag;
  logic         stored_valid;
  logic         stored_dirty;

  word_t        bank_dout [4];
  word_t        bank_din [4];
  logic [3:0]   bank_we;
  byte_mask_t   bank_wmask;
  logic [7:0]   bank_addr;     // Index, row

  logic         is_read;
  logic         hit;
  logic         fast_hit;
  logic         write_hit;
  logic         fill_beat;

  assign in_f = addr_fields_t'(cpu_req.addr);
  assign req_f = addr_fields_t'(req_q.addr);

  assign stored_tag = meta_dout[31:12];
  assign stored_valid = meta_dout[11];
  assign stored_dirty = meta_dout[10];

  assign is_read = req_q.wmask == '0;
  assign hit = stored_valid && (stored_tag == req_f.tag);

  // Read on the line just used skips the tag check
  assign fast_hit = line_ok && (cpu_req.wmask == '0) &&
                    ({in_f.tag, in_f.index} == {req_f.tag, req_f.index});

  assign write_hit = (state == meta) && hit && !is_read;
  assign fill_beat = (state == fill_wait) && mem_resp_valid;

  assign cpu_req_ready = state == idle;
  assign cpu_resp_data = bank_dout[req_f.bank];

  // Tag RAM
  assign meta_addr = (state == idle) ? in_f.index : req_f.index;
  assign meta_we = write_hit || (fill_beat && row_cnt == 2'd0); // Early, so the recheck sees it
  assign meta_din = {req_f.tag, 1'b1, write_hit, 10'b0};

  // Data banks
  assign bank_addr = (state == idle) ? {in_f.index, in_f.row} :
                     (state == meta) ? {req_f.index, req_f.row} :
                                       {req_f.index, row_cnt};
  assign bank_wmask = fill_beat ? 4'b1111 : req_q.wmask;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      bank_din[i] = fill_beat ? mem_resp_data[i*$bits(word_t) +: $bits(word_t)] : req_q.data;
      bank_we[i] = fill_beat || (write_hit && req_f.bank == bank_t'(i));
    end
  end

  // Memory side
  always_comb begin
    mem_req_valid = (state == wb_send) || (state == fill_req);
    mem_req.rw = state == wb_send;
    if (state == wb_send) begin
      mem_req.addr = {stored_tag, req_f.index, row_cnt}; // Victim line
    end else begin
      mem_req.addr = {req_f.tag, req_f.index, 2'b00};
    end
    mem_wdata_valid = state == wb_send;
    mem_wdata.data = {bank_dout[3], bank_dout[2], bank_dout[1], bank_dout[0]};
    mem_wdata.mask = '1;
  end

  always_ff @(posedge clk) begin
    if (cpu_req_valid && cpu_req_ready) begin
      req_q <= cpu_req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      row_cnt <= '0;
      line_ok <= 1'b0;
      cpu_resp_valid <= 1'b0;
    end else begin
      cpu_resp_valid <= 1'b0;
      case (state)
        idle: begin
          if (cpu_req_valid) begin
            if (fast_hit) begin
              cpu_resp_valid <= 1'b1;
            end else begin
              line_ok <= 1'b0;
              state <= meta;
            end
          end
        end
        meta: begin
          row_cnt <= '0;
          if (hit) begin
            cpu_resp_valid <= is_read; // Writes get no response
            line_ok <= 1'b1;
            state <= idle;
          end else if (stored_valid && stored_dirty) begin
            state <= wb_wait;
          end else begin
            state <= fill_req;
          end
        end
        wb_wait: begin
          // Row data settles from the bank while waiting
          if (mem_req_ready && mem_wdata_ready) begin
            state <= wb_send;
          end
        end
        wb_send: begin
          if (mem_req_ready && mem_wdata_ready) begin
            row_cnt <= row_cnt + 2'd1;
            state <= (row_cnt == 2'd3) ? fill_req : wb_wait;
          end
        end
        fill_req: begin
          if (mem_req_ready) begin
            state <= fill_wait;
          end
        end
        fill_wait: begin
          if (mem_resp_valid) begin
            row_cnt <= row_cnt + 2'd1;
            if (row_cnt == 2'd3) begin
              state <= meta; // Recheck, now a hit
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  sram_1rw #(
    .DEPTH_BITS($clog2(LINES))
  ) meta_ram (
    .clk   (clk),
    .we    (meta_we),
    .wmask (4'b1111),
    .addr  (meta_addr),
    .din   (meta_din),
    .dout  (meta_dout)
  );

  sram_1rw #(
    .DEPTH_BITS($clog2(LINES * ROWS_PER_LINE))
  ) bank0 (
    .clk   (clk),
    .we    (bank_we[0]),
    .wmask (bank_wmask),
    .addr  (bank_addr),
    .din   (bank_din[0]),
    .dout  (bank_dout[0])
  );

  sram_1rw #(
    .DEPTH_BITS($clog2(LINES * ROWS_PER_LINE))
  ) bank1 (
    .clk   (clk),
    .we    (bank_we[1]),
    .wmask (bank_wmask),
    .addr  (bank_addr),
    .din   (bank_din[1]),
    .dout  (bank_dout[1])
  );

  sram_1rw #(
    .DEPTH_BITS($clog2(LINES * ROWS_PER_LINE))
  ) bank2 (
    .clk   (clk),
    .we    (bank_we[2]),
    .wmask (bank_wmask),
    .addr  (bank_addr),
    .din   (bank_din[2]),
    .dout  (bank_dout[2])
  );

  sram_1rw #(
    .DEPTH_BITS($clog2(LINES * ROWS_PER_LINE))
  ) bank3 (
    .clk   (clk),
    .we    (bank_we[3]),
    .wmask (bank_wmask),
    .addr  (bank_addr),
    .din   (bank_din[3]),
    .dout  (bank_dout[3])
  );

endmodule

`default_nettype wire

/* main_memory.sv */
`default_nettype none

module main_memory (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   mem_req_valid,
  input  wire cache_pkg::mem_req_t    mem_req,
  input  wire logic                   mem_wdata_valid,
  input  wire cache_pkg::mem_wdata_t  mem_wdata,
  output logic                        mem_req_ready,
  output logic                        mem_wdata_ready,
  output logic                        mem_resp_valid,
  output cache_pkg::mem_data_t        mem_resp_data
);
  import cache_pkg::*;

  mem_data_t mem [2**MEM_BEAT_BITS] = '{default: '0};

  logic [MEM_LATENCY-1:0]   lat_sr;    // Read latency countdown
  logic                     rd_busy;
  logic                     streaming;
  row_t                     beat;
  logic [MEM_BEAT_BITS-3:0] rd_base;   // Line base of the burst
  logic                     rd_accept;
  logic                     wr_accept;
  logic                     send;

  assign mem_req_ready = !rd_busy;
  assign mem_wdata_ready = !rd_busy;

  assign rd_accept = mem_req_valid && mem_req_ready && !mem_req.rw;
  assign wr_accept = mem_req_valid && mem_req_ready && mem_req.rw &&
                     mem_wdata_valid && mem_wdata_ready;
  assign send = lat_sr[MEM_LATENCY-1] || streaming;

  always_ff @(posedge clk) begin
    if (reset) begin
      lat_sr <= '0;
      rd_busy <= 1'b0;
      streaming <= 1'b0;
      beat <= '0;
      mem_resp_valid <= 1'b0;
    end else begin
      lat_sr <= {lat_sr[MEM_LATENCY-2:0], rd_accept};
      mem_resp_valid <= send;
      if (rd_accept) begin
        rd_busy <= 1'b1;
      end
      if (send) begin
        beat <= beat + 2'd1;
        streaming <= beat != 2'd3;
        if (beat == 2'd3) begin
          rd_busy <= 1'b0; // Last beat leaves now
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rd_base <= mem_req.addr[MEM_BEAT_BITS-1:2];
    end
    if (wr_accept) begin
      for (int i = 0; i < $bits(mem_mask_t); i++) begin
        if (mem_wdata.mask[i]) begin
          mem[mem_req.addr[MEM_BEAT_BITS-1:0]][i*8 +: 8] <= mem_wdata.data[i*8 +: 8];
        end
      end
    end
    if (send) begin
      mem_resp_data <= mem[{rd_base, beat}];
    end
  end

endmodule

`default_nettype wire

/* cache_top.sv */
`default_nettype none

// Cache plus its backing memory, CPU port only
module cache_top (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                cpu_req_valid,
  input  wire cache_pkg::cpu_req_t cpu_req,
  output logic                     cpu_req_ready,
  output logic                     cpu_resp_valid,
  output cache_pkg::word_t         cpu_resp_data
);
  import cache_pkg::*;

  logic       mem_req_valid;
  logic       mem_req_ready;
  mem_req_t   mem_req;
  logic       mem_wdata_valid;
  logic       mem_wdata_ready;
  mem_wdata_t mem_wdata;
  logic       mem_resp_valid;
  mem_data_t  mem_resp_data;

  cache u_cache (
    .clk             (clk),
    .reset           (reset),
    .cpu_req_valid   (cpu_req_valid),
    .cpu_req         (cpu_req),
    .cpu_req_ready   (cpu_req_ready),
    .cpu_resp_valid  (cpu_resp_valid),
    .cpu_resp_data   (cpu_resp_data),
    .mem_req_valid   (mem_req_valid),
    .mem_req_ready   (mem_req_ready),
    .mem_req         (mem_req),
    .mem_wdata_valid (mem_wdata_valid),
    .mem_wdata_ready (mem_wdata_ready),
    .mem_wdata       (mem_wdata),
    .mem_resp_valid  (mem_resp_valid),
    .mem_resp_data   (mem_resp_data)
  );

  main_memory u_mem (
    .clk             (clk),
    .reset           (reset),
    .mem_req_valid   (mem_req_valid),
    .mem_req         (mem_req),
    .mem_wdata_valid (mem_wdata_valid),
    .mem_wdata       (mem_wdata),
    .mem_req_ready   (mem_req_ready),
    .mem_wdata_ready (mem_wdata_ready),
    .mem_resp_valid  (mem_resp_valid),
    .mem_resp_data   (mem_resp_data)
  );

endmodule

`default_nettype wire

/* cache_checker.sv */
`default_nettype none

// Handshake rules on the cache ports
module cache_checker (
  input wire logic                clk,
  input wire logic                reset,
  input wire logic                cpu_req_ready,
  input wire logic                cpu_resp_valid,
  input wire cache_pkg::word_t    cpu_resp_data,
  input wire logic                mem_req_valid,
  input wire cache_pkg::mem_req_t mem_req,
  input wire logic                mem_wdata_valid
);

  // Write data only travels with a write request
  wdata_with_write: assert property (@(posedge clk) disable iff (reset)
    mem_wdata_valid |-> (mem_req_valid && mem_req.rw))
    else $error("Write data valid without a write request");

  resp_in_idle: assert property (@(posedge clk) disable iff (reset)
    cpu_resp_valid |-> cpu_req_ready) // Responses leave from idle
    else $error("CPU response while the cache is busy");

  resp_known: assert property (@(posedge clk) disable iff (reset)
    cpu_resp_valid |-> !$isunknown(cpu_resp_data))
    else $error("CPU response data has unknown bits");

  quiet_after_reset: assert property (@(posedge clk)
    reset |=> !mem_req_valid)
    else $error("Memory request in the cycle after reset");

endmodule

`default_nettype wire

/* cache_tb.sv */
`default_nettype none

module cache_tb;
  import cache_pkg::*;

  localparam int resp_timeout = 200;     // Cycles allowed per handshake
  localparam int total_ops = 400;        // All tests together, with margin
  localparam int worst_op_cycles = 50;   // Write-back, fill and recheck
  localparam int watchdog_cycles = total_ops * worst_op_cycles;

  logic        clk;
  logic        reset;
  logic        cpu_req_valid;
  cpu_req_t    cpu_req;
  logic        cpu_req_ready;
  logic        cpu_resp_valid;
  word_t       cpu_resp_data;

  word_t       model [word_addr_t];     // Expected contents, zero when absent
  string       test_name;
  logic [31:0] rng_state = 32'h6a13_2b6c;
  bit          run_over;

  cache_top dut (
    .clk            (clk),
    .reset          (reset),
    .cpu_req_valid  (cpu_req_valid),
    .cpu_req        (cpu_req),
    .cpu_req_ready  (cpu_req_ready),
    .cpu_resp_valid (cpu_resp_valid),
    .cpu_resp_data  (cpu_resp_data)
  );

  bind cache cache_checker handshake_rules (
    .clk             (clk),
    .reset           (reset),
    .cpu_req_ready   (cpu_req_ready),
    .cpu_resp_valid  (cpu_resp_valid),
    .cpu_resp_data   (cpu_resp_data),
    .mem_req_valid   (mem_req_valid),
    .mem_req         (mem_req),
    .mem_wdata_valid (mem_wdata_valid)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    run_over = 1'b1;
    $display("tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_equal(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("Error: test %s, expected %h, actual %h", name, expected, actual);
      abort_run("Value mismatch");
    end
  endtask

  function automatic logic [31:0] xorshift_next();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Word address is tag, index, then word within the line
  function automatic word_addr_t make_addr(input tag_t tag, input index_t index,
                                           input logic [3:0] word);
    return {tag, index, word};
  endfunction

  function automatic word_t model_read(input word_addr_t addr);
    return model.exists(addr) ? model[addr] : '0;
  endfunction

  task automatic model_write(input word_addr_t addr, input word_t data, input byte_mask_t mask);
    word_t w;
    w = model_read(addr);
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        w[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    model[addr] = w;
  endtask

  // Called on a falling edge, returns on one
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!cpu_req_ready) begin
      @(negedge clk);
      cycles++;
      if (cycles > resp_timeout) begin
        abort_run("cpu_req_ready stayed low too long");
      end
    end
  endtask

  task automatic cpu_write(input word_addr_t addr, input word_t data, input byte_mask_t mask);
    int cycles;
    wait_ready();
    cpu_req_valid = 1'b1;
    cpu_req.addr = addr;
    cpu_req.data = data;
    cpu_req.wmask = mask;
    @(negedge clk);
    cpu_req_valid = 1'b0;
    cycles = 0;
    while (!cpu_req_ready) begin  // Done once idle again
      if (cpu_resp_valid) begin
        abort_run("A read response appeared during a write");
      end
      @(negedge clk);
      cycles++;
      if (cycles > resp_timeout) begin
        abort_run("A write did not finish in time");
      end
    end
    if (cpu_resp_valid) begin
      abort_run("A read response appeared when a write finished");
    end
    model_write(addr, data, mask);
  endtask

  task automatic cpu_read(input word_addr_t addr, output word_t data, output int latency);
    wait_ready();
    cpu_req_valid = 1'b1;
    cpu_req.addr = addr;
    cpu_req.data = '0;
    cpu_req.wmask = '0;
    @(negedge clk);
    cpu_req_valid = 1'b0;
    latency = 1;
    while (!cpu_resp_valid) begin
      @(negedge clk);
      latency++;
      if (latency > resp_timeout) begin
        abort_run("No read response arrived in time");
      end
    end
    data = cpu_resp_data;
  endtask

  task automatic read_and_check(input word_addr_t addr, output int latency);
    word_t data;
    cpu_read(addr, data, latency);
    check_equal(test_name, model_read(addr), data);
  endtask

  task automatic reset_values();
    test_name = "reset_values";
    check_equal(test_name, 32'd1, 32'(cpu_req_ready));
    check_equal(test_name, 32'd0, 32'(cpu_resp_valid));
    check_equal(test_name, 32'd0, 32'(dut.mem_req_valid));
    check_equal(test_name, 32'd0, 32'(dut.mem_wdata_valid));
    check_equal(test_name, 32'd0, 32'(dut.mem_resp_valid));
  endtask

  task automatic untouched_reads();
    int lat;
    test_name = "untouched_reads";
    read_and_check(make_addr(20'd10, 6'd0, 4'd0), lat);
    read_and_check(make_addr(20'd10, 6'd0, 4'd13), lat);
    read_and_check(make_addr(20'd11, 6'd0, 4'd5), lat);   // Clean conflict
    read_and_check(make_addr(20'd10, 6'd63, 4'd15), lat);
  endtask

  task automatic byte_merge();
    byte_mask_t masks [10] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011,
                               4'b1100, 4'b0110, 4'b1001, 4'b0111, 4'b1110};
    word_addr_t full_addr;
    word_addr_t zero_addr;
    int lat;
    test_name = "byte_merge";
    full_addr = make_addr(20'd1, 6'd5, 4'd9);
    zero_addr = make_addr(20'd1, 6'd5, 4'd2);
    cpu_write(full_addr, 32'h0123_4567, 4'hf);
    for (int i = 0; i < 10; i++) begin
      cpu_write(full_addr, xorshift_next(), masks[i]);
      read_and_check(full_addr, lat);
      cpu_write(zero_addr, xorshift_next(), masks[i]); // Merges into zero first
      read_and_check(zero_addr, lat);
    end
  endtask

  task automatic same_line_sweep();
    int lat;
    test_name = "same_line_sweep";
    for (int w = 0; w < 16; w++) begin
      cpu_write(make_addr(20'd2, 6'd12, 4'(w)), xorshift_next(), 4'hf);
    end
    for (int w = 0; w < 16; w++) begin
      read_and_check(make_addr(20'd2, 6'd12, 4'(w)), lat);
      check_equal("same_line_sweep latency", 32'd1, 32'(lat));
    end
  endtask

  task automatic conflict_eviction();
    word_addr_t a;
    word_addr_t b;
    int lat;
    test_name = "conflict_eviction";
    a = make_addr(20'd4, 6'd21, 4'd6);
    b = make_addr(20'd6, 6'd21, 4'd11);
    cpu_write(a, 32'hcafe_f00d, 4'hf);
    read_and_check(b, lat);  // Dirty victim goes back to memory
    read_and_check(a, lat);
    cpu_write(b, 32'h5eed_0001, 4'b0101);
    read_and_check(a, lat);
    read_and_check(b, lat);
  endtask

  task automatic random_traffic();
    tag_t tags [4] = '{20'd3, 20'd5, 20'd9, 20'd12};
    logic [31:0] r;
    word_addr_t addr;
    byte_mask_t mask;
    int lat;
    test_name = "random_traffic";
    for (int n = 0; n < 300; n++) begin
      r = xorshift_next();
      addr = make_addr(tags[r[1:0]], {3'b000, r[4:2]}, r[8:5]);
      if (r[9]) begin
        mask = (r[13:10] == 4'h0) ? 4'hf : r[13:10];
        cpu_write(addr, xorshift_next(), mask);
      end else begin
        read_and_check(addr, lat);
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req = '0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    reset_values();
    untouched_reads();
    byte_merge();
    same_line_sweep();
    conflict_eviction();
    random_traffic();
    run_over = 1'b1;
    $display("all tests passed");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    abort_run($sformatf("Watchdog expired after %0d cycles", watchdog_cycles));
  end

  // Run stopped by an assertion
  final begin
    if (!run_over) begin
      $display("tests failed");
    end
  end

endmodule

`default_nettype wire

/* src.f */
cache_pkg.sv
sram_1rw.sv
cache.sv
main_memory.sv
cache_top.sv
cache_checker.sv
cache_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module cache_tb -o sim_cache
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/sim_cache 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'all tests passed'; then
  exit 0
fi
exit 1
